/* project.f */
io_pkg.sv
io_dcd.sv
io_tx_fifo.sv
io_uart_tx.sv
io_reg.sv
io_top.sv
tb_io_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the io_top testbench with Verilator; exit status follows the result.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module tb_io_top -f project.f -o tb_io_top_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_io_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* tb_io_top.sv */
/* Self-checking testbench for io_top, built with FIFO_DEPTH 4 and CLKS_PER_BIT_BASE 4.
   The serial monitor takes its bit period from baud_rate_switch, so change it only while idle. */
`timescale 1ns/1ns
`default_nettype none

module tb_io_top
   import io_pkg::*;
();

   localparam int FIFO_DEPTH        = 4;
   localparam int CLKS_PER_BIT_BASE = 4;
   localparam int MAX_BIT_PERIOD    = 2 * CLKS_PER_BIT_BASE;
   localparam int FRAME_SLOTS       = 30;  // Frames plus idle gaps over all tests
   localparam int TIMEOUT_CYCLES    = FRAME_SLOTS * MAX_BIT_PERIOD * 10 + 1000;

   logic        sysclk = 1'b0;
   logic        rst = 1'b1;
   logic [4:0]  csidbs = 5'd0;
   logic [7:0]  idb_in = 8'd0;
   logic [3:0]  baud_rate_switch = 4'd0;
   wire  [15:0] idb_out;
   wire         txd;
   wire         bint12;
   wire  [1:0]  ioled;

   logic [7:0]  exp_bytes [256];
   logic [7:0]  rx_bytes [256];
   logic        rx_err [256];
   int          run_len [256];   // Lengths of low periods on txd
   int          exp_count = 0;
   int          cmp_idx = 0;
   int          rx_count = 0;
   int          run_count = 0;
   int          low_cnt = 0;
   int          cycle_count = 0;
   int          err_count = 0;
   int          check_count = 0;
   int          test_errs = 0;
   logic [31:0] rng = 32'hd76d86c0;

   always #5 sysclk = ~sysclk;

   io_top #(.FIFO_DEPTH(FIFO_DEPTH), .CLKS_PER_BIT_BASE(CLKS_PER_BIT_BASE)) UUT (
      .sysclk(sysclk),
      .rst(rst),
      .csidbs(csidbs),
      .idb_in(idb_in),
      .baud_rate_switch(baud_rate_switch),
      .idb_out(idb_out),
      .txd(txd),
      .bint12(bint12),
      .ioled(ioled)
   );

   always @(posedge sysclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Result: FAILED");
         $finish;
      end
   end

   always @(posedge sysclk) begin
      if (rst) begin
         low_cnt <= 0;
      end else if (txd == 1'b0) begin
         low_cnt <= low_cnt + 1;
      end else if (low_cnt != 0) begin
         run_len[run_count] <= low_cnt;
         run_count          <= run_count + 1;
         low_cnt            <= 0;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int bit_period();
      return CLKS_PER_BIT_BASE * (int'(baud_rate_switch) + 1);
   endfunction

   // 8N1 frame decoder, samples mid-bit
   always begin : serial_monitor
      int         p;
      logic [7:0] data;
      logic       bad;
      @(negedge txd);
      if (!rst) begin
         p = bit_period();
         repeat (p / 2) @(posedge sysclk);
         bad = (txd != 1'b0);
         for (int i = 0; i < 8; i++) begin
            repeat (p) @(posedge sysclk);
            data[i] = txd;
         end
         repeat (p) @(posedge sysclk);
         if (txd != 1'b1) bad = 1'b1;  // Stop bit
         rx_bytes[rx_count] = data;
         rx_err[rx_count]   = bad;
         rx_count           = rx_count + 1;
      end
   end

   task automatic check(input logic cond, input string msg);
      check_count++;
      assert (cond) else begin
         $display("CHECK FAILED at %0t ns: %s", $time, msg);
         err_count++;
      end
   endtask

   task automatic drive_cmd(input logic [4:0] cmd, input logic [7:0] data);
      @(posedge sysclk);
      csidbs <= cmd;
      idb_in <= data;
   endtask

   task automatic write_byte(input logic [7:0] data);
      drive_cmd(CMD_WRITE_TX, data);
      drive_cmd(CMD_NOP, 8'h00);
      exp_bytes[exp_count] = data;
      exp_count++;
   endtask

   task automatic write_ctrl(input logic [7:0] data);
      drive_cmd(CMD_WRITE_CTRL, data);
      drive_cmd(CMD_NOP, 8'h00);
   endtask

   task automatic read_word(input logic [4:0] cmd, output logic [15:0] word);
      drive_cmd(cmd, 8'h00);
      drive_cmd(CMD_NOP, 8'h00);
      @(negedge sysclk);
      check(idb_out === 16'h0000, "idb_out not zero outside a read");
      @(negedge sysclk);
      word = idb_out;
      @(negedge sysclk);
      check(idb_out === 16'h0000, "idb_out held longer than one cycle");
   endtask

   task automatic compare_rx();
      while (rx_count < exp_count) @(negedge sysclk);
      for (int i = cmp_idx; i < exp_count; i++) begin
         check(!rx_err[i], $sformatf("frame %0d has a bad start or stop bit", i));
         check(rx_bytes[i] === exp_bytes[i],
               $sformatf("frame %0d got %h, expected %h", i, rx_bytes[i], exp_bytes[i]));
      end
      cmp_idx = exp_count;
   endtask

   task automatic idle_frame();
      repeat (10 * bit_period()) @(posedge sysclk);
   endtask

   task automatic report_test(input string name);
      $display("Test %s: %0d errors", name, err_count - test_errs);
      test_errs = err_count;
   endtask

   initial begin : stimulus
      logic [15:0] w;
      logic        saw_high;
      int          waited;
      int          snap;
      int          min_run;
      repeat (8) @(posedge sysclk);
      rst <= 1'b0;
      @(negedge sysclk);
      check(txd === 1'b1 && bint12 === 1'b0 && ioled === 2'b00, "outputs wrong after reset");
      read_word(CMD_READ_STATUS, w);
      check(w === 16'(1 << STAT_BUF_EMPTY), $sformatf("status after reset is %h", w));
      read_word(CMD_READ_CTRL, w);
      check(w === 16'h0000, $sformatf("control after reset is %h", w));
      report_test("reset state");

      for (int i = 0; i < 8; i++) begin
         rng = xorshift32(rng);
         write_byte(rng[7:0]);
         compare_rx();
         idle_frame();
      end
      check(rx_count == exp_count, "unexpected extra frames on txd");
      report_test("random bytes");

      for (int i = 0; i < 6; i++) begin  // Back-to-back writes
         rng = xorshift32(rng);
         drive_cmd(CMD_WRITE_TX, rng[7:0]);
         if (i < FIFO_DEPTH + 1) begin
            exp_bytes[exp_count] = rng[7:0];
            exp_count++;
         end
      end
      drive_cmd(CMD_NOP, 8'h00);
      read_word(CMD_READ_STATUS, w);
      // First frame still on the line, no credit left
      check(w === 16'((1 << STAT_TX_BUSY) | (1 << STAT_OVERRUN) | (1 << STAT_BUF_FULL)),
            $sformatf("status after burst is %h", w));
      check(ioled[0] === 1'b1, "overrun LED not lit");
      compare_rx();
      idle_frame();
      check(rx_count == exp_count, "more than FIFO_DEPTH+1 bytes accepted in burst");
      report_test("overrun burst");

      drive_cmd(CMD_CLEAR_OVR, 8'h00);
      drive_cmd(CMD_NOP, 8'h00);
      read_word(CMD_READ_STATUS, w);
      check(w === 16'(1 << STAT_BUF_EMPTY) && ioled[0] === 1'b0, "overrun not cleared");
      write_ctrl(8'((1 << CTRL_TX_IE) | (1 << CTRL_CONSOLE)));
      read_word(CMD_READ_CTRL, w);
      check(w === 16'((1 << CTRL_TX_IE) | (1 << CTRL_CONSOLE)) && ioled[1] === 1'b1,
            $sformatf("control read back %h", w));
      write_ctrl(8'h00);
      read_word(CMD_READ_CTRL, w);
      check(w === 16'h0000 && ioled[1] === 1'b0, "console bit did not clear");
      report_test("clear and control");

      write_ctrl(8'(1 << CTRL_TX_IE));
      repeat (3) @(negedge sysclk);
      check(bint12 === 1'b1, "no interrupt while idle with enable set");
      for (int i = 0; i < 2; i++) begin
         rng = xorshift32(rng);
         write_byte(rng[7:0]);
         repeat (2) @(negedge sysclk);  // Credit taken, then bint12 registers
         check(bint12 === 1'b0, "bint12 did not fall after a write");
      end
      saw_high = 1'b0;
      while (rx_count < exp_count) begin
         @(negedge sysclk);
         if (bint12) saw_high = 1'b1;
      end
      check(!saw_high, "bint12 high while bytes were pending");
      waited = 0;
      while (!bint12 && waited < 4 * bit_period()) begin
         @(negedge sysclk);
         waited++;
      end
      check(bint12 === 1'b1 && txd === 1'b1, "bint12 did not rise after the last stop bit");
      rng = xorshift32(rng);
      write_byte(rng[7:0]);
      repeat (2) @(negedge sysclk);
      check(bint12 === 1'b0, "bint12 did not fall after a new write");
      compare_rx();
      idle_frame();
      report_test("interrupt");

      @(posedge sysclk);
      baud_rate_switch <= 4'd1;
      @(posedge sysclk);
      snap = run_count;
      write_byte(8'h55);  // Bit 0 set, so the start bit is a single low bit
      compare_rx();
      rng = xorshift32(rng);
      write_byte(rng[7:0]);
      compare_rx();
      idle_frame();
      min_run = 1000;
      for (int i = snap; i < run_count; i++) begin
         if (run_len[i] < min_run) min_run = run_len[i];
      end
      check(min_run == 2 * CLKS_PER_BIT_BASE, $sformatf("bit period measured %0d", min_run));
      report_test("baud switch");

      $display("Tests: 6, checks: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* io_top.sv */
/* Terminal output channel: decoder, transmit buffer, serial transmitter, registers.
   Only the register block drives the data bus, so idb_out is wired straight through. */
`timescale 1ns/1ns
`default_nettype none

module io_top #(
   parameter int FIFO_DEPTH        = 4,
   parameter int CLKS_PER_BIT_BASE = 4
) (
   input  wire         sysclk,
   input  wire         rst,
   input  wire  [4:0]  csidbs,
   input  wire  [7:0]  idb_in,
   input  wire  [3:0]  baud_rate_switch,
   output wire  [15:0] idb_out,
   output wire         txd,
   output wire         bint12,
   output wire  [1:0]  ioled
);

   wire       s_push;
   wire [7:0] s_push_data;
   wire       s_credit_return;
   wire       s_buf_empty;
   wire       s_buf_full;
   wire       s_overrun_pulse;
   wire       s_wr_ctrl;
   wire       s_rd_status;
   wire       s_rd_ctrl;
   wire       s_clr_ovr;
   wire [7:0] s_wr_data;
   wire       s_tx_ready;
   wire       s_tx_load;
   wire [7:0] s_tx_data;
   wire       s_tx_busy;

   io_dcd #(.FIFO_DEPTH(FIFO_DEPTH)) DCD (
      .sysclk(sysclk),
      .rst(rst),
      .csidbs(csidbs),
      .idb_in(idb_in),
      .credit_return(s_credit_return),
      .push(s_push),
      .push_data(s_push_data),
      .buf_empty(s_buf_empty),
      .buf_full(s_buf_full),
      .overrun_pulse(s_overrun_pulse),
      .wr_ctrl(s_wr_ctrl),
      .rd_status(s_rd_status),
      .rd_ctrl(s_rd_ctrl),
      .clr_ovr(s_clr_ovr),
      .wr_data(s_wr_data)
   );

   io_tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) TXBUF (
      .sysclk(sysclk),
      .rst(rst),
      .push(s_push),
      .push_data(s_push_data),
      .tx_ready(s_tx_ready),
      .tx_load(s_tx_load),
      .tx_data(s_tx_data),
      .credit_return(s_credit_return)
   );

   io_uart_tx #(.CLKS_PER_BIT_BASE(CLKS_PER_BIT_BASE)) UART (
      .sysclk(sysclk),
      .rst(rst),
      .baud_rate_switch(baud_rate_switch),
      .tx_load(s_tx_load),
      .tx_data(s_tx_data),
      .tx_ready(s_tx_ready),
      .tx_busy(s_tx_busy),
      .txd(txd)
   );

   io_reg REG_MODULE (
      .sysclk(sysclk),
      .rst(rst),
      .wr_ctrl(s_wr_ctrl),
      .rd_status(s_rd_status),
      .rd_ctrl(s_rd_ctrl),
      .clr_ovr(s_clr_ovr),
      .wr_data(s_wr_data),
      .overrun_pulse(s_overrun_pulse),
      .buf_empty(s_buf_empty),
      .buf_full(s_buf_full),
      .tx_busy(s_tx_busy),
      .idb_out(idb_out),
      .bint12(bint12),
      .ioled(ioled)
   );

endmodule

`default_nettype wire

/* io_reg.sv */
/* Control and status registers with bus read-back, transmit interrupt and LEDs.
   bint12 is a level request while the interrupt is enabled and the channel is idle. */
`timescale 1ns/1ns
`default_nettype none

module io_reg
   import io_pkg::*;
(
   input  wire         sysclk,
   input  wire         rst,
   input  wire         wr_ctrl,
   input  wire         rd_status,
   input  wire         rd_ctrl,
   input  wire         clr_ovr,
   input  wire  [7:0]  wr_data,
   input  wire         overrun_pulse,
   input  wire         buf_empty,
   input  wire         buf_full,
   input  wire         tx_busy,
   output logic [15:0] idb_out,
   output logic        bint12,
   output logic [1:0]  ioled
);

   logic [1:0] ctrl_reg;     // Interrupt enable and console
   logic       overrun;
   logic [7:0] status_word;
   logic [7:0] ctrl_word;

   always_comb begin
      status_word                 = '0;
      status_word[STAT_BUF_EMPTY] = buf_empty;
      status_word[STAT_TX_BUSY]   = tx_busy;
      status_word[STAT_OVERRUN]   = overrun;
      status_word[STAT_BUF_FULL]  = buf_full;
   end

   assign ctrl_word = {6'd0, ctrl_reg};

   always_ff @(posedge sysclk) begin
      if (rst) begin
         ctrl_reg <= '0;
         overrun  <= 1'b0;
         idb_out  <= '0;
         bint12   <= 1'b0;
      end else begin
         if (wr_ctrl) begin
            ctrl_reg[CTRL_TX_IE]   <= wr_data[CTRL_TX_IE];
            ctrl_reg[CTRL_CONSOLE] <= wr_data[CTRL_CONSOLE];
         end
         if (overrun_pulse) begin
            overrun <= 1'b1; // Set wins over clear
         end else if (clr_ovr) begin
            overrun <= 1'b0;
         end
         if (rd_status) begin
            idb_out <= {8'd0, status_word};
         end else if (rd_ctrl) begin
            idb_out <= {8'd0, ctrl_word};
         end else begin
            idb_out <= '0;  // Bus is OR-combined, idle at zero
         end
         bint12 <= ctrl_reg[CTRL_TX_IE] & buf_empty & ~tx_busy;
      end
   end

   assign ioled = {ctrl_reg[CTRL_CONSOLE], overrun}; // Green, red

endmodule

`default_nettype wire

/* io_uart_tx.sv */
/* 8N1 serial transmitter. Bit period is CLKS_PER_BIT_BASE * (baud_rate_switch + 1)
   clocks, sampled when a byte is loaded. */
`timescale 1ns/1ns
`default_nettype none

module io_uart_tx
   import io_pkg::*;
#(
   parameter int CLKS_PER_BIT_BASE = 4
) (
   input  wire        sysclk,
   input  wire        rst,
   input  wire  [3:0] baud_rate_switch,
   input  wire        tx_load,
   input  wire  [7:0] tx_data,
   output logic       tx_ready,
   output logic       tx_busy,
   output logic       txd
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT_BASE * 16 + 1);

   tx_state_e        state;
   logic [CNT_W-1:0] period_sel;
   logic [CNT_W-1:0] bit_period; // Latched per frame
   logic [CNT_W-1:0] clk_cnt;
   logic [2:0]       bit_idx;
   logic [7:0]       shift_reg;
   logic             bit_done;

   assign period_sel = CNT_W'(CLKS_PER_BIT_BASE * (int'(baud_rate_switch) + 1));
   assign bit_done   = (clk_cnt == bit_period - 1'b1);
   assign tx_ready   = (state == TX_IDLE);
   assign tx_busy    = (state != TX_IDLE);

   always_ff @(posedge sysclk) begin
      if (rst) begin
         state   <= TX_IDLE;
         txd     <= 1'b1;  // Line idles high
         clk_cnt <= '0;
         bit_idx <= '0;
      end else begin
         clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               clk_cnt <= '0;
               if (tx_load) begin
                  state <= TX_START;
                  txd   <= 1'b0; // Start bit
               end
            end
            TX_START: begin
               if (bit_done) begin
                  state   <= TX_DATA;
                  txd     <= shift_reg[0];
                  bit_idx <= '0;
               end
            end
            TX_DATA: begin
               if (bit_done) begin
                  if (bit_idx == 3'd7) begin
                     state <= TX_STOP;
                     txd   <= 1'b1; // Stop bit
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                     txd     <= shift_reg[1]; // LSB first
                  end
               end
            end
            TX_STOP: begin
               if (bit_done) begin
                  state <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge sysclk) begin
      if (state == TX_IDLE && tx_load) begin
         shift_reg  <= tx_data;
         bit_period <= period_sel;
      end else if (state == TX_DATA && bit_done) begin
         shift_reg <= {1'b0, shift_reg[7:1]};
      end
   end

endmodule

`default_nettype wire

/* io_tx_fifo.sv */
/* Transmit byte buffer. Relies on the decoder's credits and never checks for full.
   FIFO_DEPTH must be a power of two so the pointers wrap naturally. */
`timescale 1ns/1ns
`default_nettype none

module io_tx_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire        sysclk,
   input  wire        rst,
   input  wire        push,
   input  wire  [7:0] push_data,
   input  wire        tx_ready,
   output logic       tx_load,
   output logic [7:0] tx_data,
   output logic       credit_return
);

   localparam int AW = $clog2(FIFO_DEPTH);

   logic [7:0]  mem [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          pop;

   assign pop     = (count != '0) && tx_ready;  // Hand over as soon as UART idles
   assign tx_load = pop;
   assign tx_data = mem[rd_ptr];

   always_ff @(posedge sysclk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge sysclk) begin
      if (rst) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         credit_return <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count         <= count + (AW+1)'(push) - (AW+1)'(pop);
         credit_return <= pop; // One credit back per byte sent on
      end
   end

endmodule

`default_nettype wire

/* io_dcd.sv */
/* Command decoder and credit holder for the transmit buffer.
   A transmit write with no credit left is dropped and reported on overrun_pulse. */
`timescale 1ns/1ns
`default_nettype none

module io_dcd
   import io_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input  wire        sysclk,
   input  wire        rst,
   input  wire  [4:0] csidbs,
   input  wire  [7:0] idb_in,
   input  wire        credit_return,
   output logic       push,
   output logic [7:0] push_data,
   output logic       buf_empty,
   output logic       buf_full,
   output logic       overrun_pulse,
   output logic       wr_ctrl,
   output logic       rd_status,
   output logic       rd_ctrl,
   output logic       clr_ovr,
   output logic [7:0] wr_data
);

   localparam int CW = $clog2(FIFO_DEPTH + 1);

   io_cmd_e       cmd;
   logic [CW-1:0] credits;       // Free slots in the buffer
   logic          is_write_tx;
   logic          take_write;

   assign cmd         = io_cmd_e'(csidbs);
   assign is_write_tx = (cmd == CMD_WRITE_TX);
   assign take_write  = is_write_tx && (credits != '0);

   // All credits home means nothing queued
   assign buf_empty = (credits == CW'(FIFO_DEPTH));
   assign buf_full  = (credits == '0);

   always_ff @(posedge sysclk) begin
      if (rst) begin
         credits <= CW'(FIFO_DEPTH);
      end else begin
         credits <= credits + CW'(credit_return) - CW'(take_write); // Both may hit at once
      end
   end

   always_ff @(posedge sysclk) begin
      if (rst) begin
         push          <= 1'b0;
         overrun_pulse <= 1'b0;
         wr_ctrl       <= 1'b0;
         rd_status     <= 1'b0;
         rd_ctrl       <= 1'b0;
         clr_ovr       <= 1'b0;
      end else begin
         push          <= take_write;
         overrun_pulse <= is_write_tx && (credits == '0); // Dropped byte
         wr_ctrl       <= (cmd == CMD_WRITE_CTRL);
         rd_status     <= (cmd == CMD_READ_STATUS);
         rd_ctrl       <= (cmd == CMD_READ_CTRL);
         clr_ovr       <= (cmd == CMD_CLEAR_OVR);
      end
   end

   // Data byte follows its strobe
   always_ff @(posedge sysclk) begin
      if (take_write) begin
         push_data <= idb_in;
      end
      if (cmd == CMD_WRITE_CTRL) begin
         wr_data <= idb_in;
      end
   end

endmodule

`default_nettype wire

/* io_pkg.sv */
/* Shared definitions for the terminal output channel.
   Bus command codes not listed in io_cmd_e are treated as no-ops by the decoder. */
`default_nettype none

package io_pkg;

   // Microcode field on csidbs
   typedef enum logic [4:0] {
      CMD_NOP         = 5'd0,
      CMD_WRITE_TX    = 5'd1,
      CMD_READ_STATUS = 5'd2,
      CMD_WRITE_CTRL  = 5'd3,
      CMD_READ_CTRL   = 5'd4,
      CMD_CLEAR_OVR   = 5'd5
   } io_cmd_e;

   // Serial transmitter FSM
   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,
      TX_START = 2'd1,
      TX_DATA  = 2'd2,
      TX_STOP  = 2'd3
   } tx_state_e;

   // Status word bit positions
   parameter int STAT_BUF_EMPTY = 0;
   parameter int STAT_TX_BUSY   = 1;
   parameter int STAT_OVERRUN   = 2;
   parameter int STAT_BUF_FULL  = 3;

   // Control word bit positions
   parameter int CTRL_TX_IE     = 0;
   parameter int CTRL_CONSOLE   = 1;

endpackage

`default_nettype wire
